// File: rtl/cache_defines.svh
// ------------------------------------------------
// Cache geometry macros shared by RTL and testbench
// ------------------------------------------------

`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// Bus widths
`define CACHE_ADDR_W      32  // AHB address width
`define CACHE_DATA_W      32  // AHB data width, both sides

// Line and capacity
`define CACHE_LINE_WORDS  4   // One INCR4 burst per line
`define CACHE_DEPTH_WORDS 64  // 16 lines of 4 words

// Byte lanes per bus word
`define CACHE_BYTES_W     4

`endif

// File: rtl/cache_pkg.sv
// ------------------------------------------------
// Cache types: addresses, words, tags, FSM and HTRANS
// ------------------------------------------------

`include "cache_defines.svh"

package cache_pkg;

	// Bus level
	typedef logic [`CACHE_ADDR_W-1:0]                 addr_t;
	typedef logic [`CACHE_DATA_W-1:0]                 word_t;
	typedef logic [`CACHE_DATA_W/`CACHE_BYTES_W-1:0]  byte_t;     // One lane
	typedef logic [`CACHE_BYTES_W-1:0]                byte_en_t;  // Per-lane write mask

	// Address split: tag | line index | word | byte offset
	typedef logic [$clog2(`CACHE_DEPTH_WORDS/`CACHE_LINE_WORDS)-1:0] line_idx_t;
	typedef logic [$clog2(`CACHE_LINE_WORDS)-1:0]                     word_sel_t;
	typedef logic [`CACHE_ADDR_W-$clog2(`CACHE_DEPTH_WORDS)-$clog2(`CACHE_BYTES_W)-1:0] tag_t;

	// Tag store entry
	typedef struct packed {
		logic valid;  // Line holds fetched data
		logic dirty;  // Line differs from memory
		tag_t tag;
	} tag_entry_t;

	// Controller states; BURST has aphase and dphase in flight, LAST only the dphase
	typedef enum logic [4:0] {
		S_IDLE, S_READ_CHECK, S_READ_CLEAN_BURST, S_READ_CLEAN_LAST,
		S_READ_FILL_BURST, S_READ_FILL_LAST, S_READ_DONE,
		S_WRITE_CHECK, S_WRITE_CLEAN_BURST, S_WRITE_CLEAN_LAST,
		S_WRITE_FILL_BURST, S_WRITE_FILL_LAST, S_WRITE_MODIFY, S_WRITE_DONE
	} cache_state_t;

	// AHB transfer type, BUSY not used
	typedef enum logic [1:0] {
		HTRANS_IDLE   = 2'b00,
		HTRANS_NONSEQ = 2'b10,
		HTRANS_SEQ    = 2'b11
	} htrans_t;

endpackage

// File: rtl/cache_sram.sv
// ------------------------------------------------
// Single-port synchronous RAM, registered read
// ------------------------------------------------

`timescale 1ns/10ps

module cache_sram #(
	parameter type entry_t = logic [7:0],  // Payload of one entry
	parameter int  DEPTH   = 16
) (
	input  logic                     clk,
	input  logic [$clog2(DEPTH)-1:0] addr,
	input  logic                     en,     // Access strobe
	input  logic                     we,     // Write when set, else read
	input  entry_t                   wdata,
	output entry_t                   rdata
);

	entry_t mem [DEPTH];  // Contents, no reset sweep

	// Read data holds until the next read access
	always_ff @(posedge clk) begin
		if (en) begin
			if (we) begin
				mem[addr] <= wdata;
			end else begin
				rdata <= mem[addr];  // Valid one cycle after en
			end
		end
	end

endmodule

// File: rtl/cache_src_capture.sv
// ------------------------------------------------
// Upstream AHB-Lite address phase decode and capture
// ------------------------------------------------

`timescale 1ns/10ps
`include "cache_defines.svh"

module cache_src_capture (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                src_hready,
	input  cache_pkg::htrans_t  src_htrans,
	input  logic                src_hwrite,
	input  cache_pkg::addr_t    src_haddr,
	input  logic [2:0]          src_hsize,
	output logic                aphase_read,   // Accepted read aphase
	output logic                aphase_write,  // Accepted write aphase
	output cache_pkg::addr_t    dph_addr,      // Address of current data phase
	output cache_pkg::byte_en_t dph_byte_en    // Lanes touched in data phase
);
	import cache_pkg::*;

	localparam int OFS_W = $clog2(`CACHE_BYTES_W);  // Byte offset bits

	logic     aphase;
	byte_en_t byte_en_nxt;

	// Transfer taken when bus ready and NONSEQ or SEQ
	assign aphase = src_hready && (src_htrans == HTRANS_NONSEQ || src_htrans == HTRANS_SEQ);
	assign aphase_read  = aphase && !src_hwrite;
	assign aphase_write = aphase && src_hwrite;

	// Lane mask from size and low address bits
	always_comb begin
		case (src_hsize)
			3'd0:    byte_en_nxt = byte_en_t'(1) << src_haddr[OFS_W-1:0];  // Byte
			3'd1:    byte_en_nxt = byte_en_t'(3) << {src_haddr[1], 1'b0};   // Halfword
			default: byte_en_nxt = '1;                                      // Word
		endcase
	end

	// ------------------------------------------------
	// Data phase registers
	// ------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dph_addr    <= '0;
			dph_byte_en <= '0;
		end else if (aphase) begin
			dph_addr    <= src_haddr;
			dph_byte_en <= byte_en_nxt;
		end
	end

endmodule

// File: rtl/cache_burst_ctr.sv
// ------------------------------------------------
// Beat counter for downstream fill and clean bursts
// ------------------------------------------------

`timescale 1ns/10ps

module cache_burst_ctr (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 step,      // Active transfer accepted downstream
	input  logic                 clear,     // Idle transfer accepted downstream
	input  cache_pkg::word_sel_t src_word,  // Word requested upstream
	output cache_pkg::word_sel_t count,     // Word of current address phase
	output logic                 last_beat,
	output logic                 hit_word   // Current dphase carries src_word
);

	// Final aphase of a four-beat burst
	assign last_beat = &count;

	// Counter wraps, so a clean runs straight into the fill at word 0
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			count    <= '0;
			hit_word <= 1'b0;
		end else if (clear) begin
			count    <= '0;
			hit_word <= 1'b0;
		end else if (step) begin
			count    <= count + 1'b1;
			hit_word <= count == src_word;  // Aphase word now moves to dphase
		end
	end

endmodule

// File: rtl/cache_ctrl.sv
// ------------------------------------------------
// Cache controller: FSM, hit decode, SRAM steering,
// downstream bursts and upstream response
// ------------------------------------------------

`timescale 1ns/10ps
`include "cache_defines.svh"

module cache_ctrl (
	input  logic                    clk,
	input  logic                    rst_n,
	// Upstream
	input  logic                    aphase_read,
	input  logic                    aphase_write,
	input  cache_pkg::addr_t        src_haddr,
	input  cache_pkg::addr_t        dph_addr,
	input  cache_pkg::byte_en_t     dph_byte_en,
	input  cache_pkg::word_t        src_hwdata,
	output logic                    src_hready_resp,
	output cache_pkg::word_t        src_hrdata,
	// Downstream
	input  logic                    dst_hready,
	input  cache_pkg::word_t        dst_hrdata,
	output cache_pkg::addr_t        dst_haddr,
	output logic                    dst_hwrite,
	output cache_pkg::htrans_t      dst_htrans,
	output cache_pkg::word_t        dst_hwdata,
	// Burst counter
	output logic                    burst_step,
	output logic                    burst_clear,
	input  cache_pkg::word_sel_t    burst_count,
	input  logic                    burst_last,
	input  logic                    burst_hit_word,
	// Tag store
	output cache_pkg::line_idx_t    tag_addr,
	output logic                    tag_en,
	output logic                    tag_we,
	output cache_pkg::tag_entry_t   tag_wdata,
	input  cache_pkg::tag_entry_t   tag_rdata,
	// Data store, all lanes share address
	output logic [$clog2(`CACHE_DEPTH_WORDS)-1:0] data_addr,
	output logic                    data_en,
	output cache_pkg::byte_en_t     data_we,
	output cache_pkg::word_t        data_wdata,
	input  cache_pkg::word_t        data_rdata
);
	import cache_pkg::*;

	localparam int WORD_LSB = $clog2(`CACHE_BYTES_W);
	localparam int IDX_LSB  = WORD_LSB + $bits(word_sel_t);
	localparam int TAG_LSB  = IDX_LSB + $bits(line_idx_t);

	cache_state_t state, next_src;
	logic [2**$bits(line_idx_t)-1:0] line_valid;  // Cleared on reset, set on tag write
	word_t        fill_word;                      // Requested word from the fill

	line_idx_t dph_idx, src_idx;
	word_sel_t dph_word, src_word, fill_wsel;
	tag_t      dph_tag;
	logic      line_ok, hit, dirty;
	logic      in_check, in_clean_burst, in_clean_last, in_fill_burst, in_fill_last;
	logic      clean_aph, fill_dph, fill_wr, modify, src_aph;

	// Address fields
	assign dph_idx   = dph_addr[IDX_LSB +: $bits(line_idx_t)];
	assign dph_word  = dph_addr[WORD_LSB +: $bits(word_sel_t)];
	assign dph_tag   = dph_addr[TAG_LSB +: $bits(tag_t)];
	assign src_idx   = src_haddr[IDX_LSB +: $bits(line_idx_t)];
	assign src_word  = src_haddr[WORD_LSB +: $bits(word_sel_t)];
	assign fill_wsel = burst_count - 1'b1;  // Dphase trails aphase by one beat

	// Lookup result, tag_rdata is from the aphase read
	assign line_ok = line_valid[dph_idx] && tag_rdata.valid;
	assign hit     = line_ok && tag_rdata.tag == dph_tag;
	assign dirty   = line_ok && tag_rdata.dirty;

	// State groups
	assign in_check       = state == S_READ_CHECK || state == S_WRITE_CHECK;
	assign in_clean_burst = state == S_READ_CLEAN_BURST || state == S_WRITE_CLEAN_BURST;
	assign in_clean_last  = state == S_READ_CLEAN_LAST || state == S_WRITE_CLEAN_LAST;
	assign in_fill_burst  = state == S_READ_FILL_BURST || state == S_WRITE_FILL_BURST;
	assign in_fill_last   = state == S_READ_FILL_LAST || state == S_WRITE_FILL_LAST;

	assign clean_aph = (in_check && !hit && dirty) || in_clean_burst;  // Dirty line going out
	assign fill_dph  = in_fill_burst || in_fill_last;                   // Fill word on dst_hrdata
	assign fill_wr   = fill_dph && dst_hready;
	assign modify    = (state == S_WRITE_CHECK && hit) || state == S_WRITE_MODIFY;
	assign src_aph   = aphase_read || aphase_write;

	assign next_src = aphase_read ? S_READ_CHECK : aphase_write ? S_WRITE_CHECK : S_IDLE;

	// ------------------------------------------------
	// State machine
	// ------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= S_IDLE;
		end else begin
			case (state)
				S_IDLE, S_READ_DONE, S_WRITE_DONE: state <= next_src;
				S_READ_CHECK: begin
					if (hit)
						state <= next_src;  // Zero-wait hit, pipelined
					else if (dst_hready)
						state <= dirty ? S_READ_CLEAN_BURST : S_READ_FILL_BURST;
				end
				S_READ_CLEAN_BURST: if (dst_hready && burst_last) state <= S_READ_CLEAN_LAST;
				S_READ_CLEAN_LAST:  if (dst_hready) state <= S_READ_FILL_BURST;
				S_READ_FILL_BURST:  if (dst_hready && burst_last) state <= S_READ_FILL_LAST;
				S_READ_FILL_LAST:   if (dst_hready) state <= S_READ_DONE;
				S_WRITE_CHECK: begin
					if (hit)
						state <= S_WRITE_DONE;  // Bytes merged this cycle
					else if (dst_hready)
						state <= dirty ? S_WRITE_CLEAN_BURST : S_WRITE_FILL_BURST;
				end
				S_WRITE_CLEAN_BURST: if (dst_hready && burst_last) state <= S_WRITE_CLEAN_LAST;
				S_WRITE_CLEAN_LAST:  if (dst_hready) state <= S_WRITE_FILL_BURST;
				S_WRITE_FILL_BURST:  if (dst_hready && burst_last) state <= S_WRITE_FILL_LAST;
				S_WRITE_FILL_LAST:   if (dst_hready) state <= S_WRITE_MODIFY;
				S_WRITE_MODIFY:      state <= S_WRITE_DONE;  // Merge after the fill
				default:             state <= S_IDLE;
			endcase
		end
	end

	// Valid bits live here, so the tag RAM needs no init
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			line_valid <= '0;
		else if (tag_we)
			line_valid[dph_idx] <= 1'b1;
	end

	// Keep the requested word as it passes by
	always_ff @(posedge clk) begin
		if (fill_wr && burst_hit_word)
			fill_word <= dst_hrdata;
	end

	// ------------------------------------------------
	// SRAM steering
	// ------------------------------------------------
	assign tag_we    = modify || (in_fill_last && dst_hready);
	assign tag_en    = src_aph || tag_we;
	assign tag_addr  = tag_we ? dph_idx : src_idx;
	assign tag_wdata = '{valid: 1'b1, dirty: modify, tag: dph_tag};

	always_comb begin
		if (clean_aph)
			data_addr = {dph_idx, burst_count};  // Prefetch word for next clean dphase
		else if (fill_dph)
			data_addr = {dph_idx, fill_wsel};
		else if (modify)
			data_addr = {dph_idx, dph_word};
		else
			data_addr = {src_idx, src_word};     // Lookup for a new aphase
	end

	assign data_en    = src_aph || (clean_aph && dst_hready) || fill_wr || modify;
	assign data_we    = fill_wr ? '1 : modify ? dph_byte_en : '0;
	assign data_wdata = fill_dph ? dst_hrdata : src_hwdata;

	// ------------------------------------------------
	// Downstream request
	// ------------------------------------------------
	assign dst_haddr = clean_aph
		? {tag_rdata.tag, dph_idx, burst_count, {WORD_LSB{1'b0}}}  // Victim line
		: {dph_tag, dph_idx, burst_count, {WORD_LSB{1'b0}}};       // Missed line

	always_comb begin
		if ((in_check && !hit) || in_clean_last)
			dst_htrans = HTRANS_NONSEQ;  // First beat of clean or fill
		else if (in_clean_burst || in_fill_burst)
			dst_htrans = HTRANS_SEQ;
		else
			dst_htrans = HTRANS_IDLE;
	end

	assign dst_hwrite = clean_aph;
	assign dst_hwdata = data_rdata;  // Only meaningful in clean dphases

	assign burst_step  = dst_hready && dst_htrans != HTRANS_IDLE;
	assign burst_clear = dst_hready && dst_htrans == HTRANS_IDLE;

	// Upstream response
	assign src_hready_resp = state == S_IDLE || (state == S_READ_CHECK && hit) ||
		state == S_READ_DONE || state == S_WRITE_DONE;
	assign src_hrdata = state == S_READ_DONE ? fill_word : data_rdata;

endmodule

// File: rtl/ahb_cache_top.sv
// ------------------------------------------------
// Write-back AHB-Lite cache top, capture, counter,
// controller, tag RAM and four data lanes
// ------------------------------------------------

`timescale 1ns/10ps
`include "cache_defines.svh"

module ahb_cache_top (
	input  logic               clk,
	input  logic               rst_n,
	// Upstream AHB-Lite slave
	input  logic               src_hready,
	input  cache_pkg::addr_t   src_haddr,
	input  logic               src_hwrite,
	input  cache_pkg::htrans_t src_htrans,
	input  logic [2:0]         src_hsize,
	input  cache_pkg::word_t   src_hwdata,
	output logic               src_hready_resp,
	output cache_pkg::word_t   src_hrdata,
	// Downstream AHB-Lite master
	input  logic               dst_hready_resp,
	output logic               dst_hready,
	output cache_pkg::addr_t   dst_haddr,
	output logic               dst_hwrite,
	output cache_pkg::htrans_t dst_htrans,
	output cache_pkg::word_t   dst_hwdata,
	input  cache_pkg::word_t   dst_hrdata
);
	import cache_pkg::*;

	logic       aphase_read, aphase_write;
	addr_t      dph_addr;
	byte_en_t   dph_byte_en;
	logic       burst_step, burst_clear, burst_last, burst_hit_word;
	word_sel_t  burst_count;
	line_idx_t  tag_addr;
	logic       tag_en, tag_we;
	tag_entry_t tag_wdata, tag_rdata;
	logic [$clog2(`CACHE_DEPTH_WORDS)-1:0] data_addr;
	logic       data_en;
	byte_en_t   data_we;
	word_t      data_wdata, data_rdata;

	assign dst_hready = dst_hready_resp;  // Single downstream slave

	cache_src_capture u_capture (
		.clk, .rst_n, .src_hready, .src_htrans, .src_hwrite, .src_haddr, .src_hsize,
		.aphase_read, .aphase_write, .dph_addr, .dph_byte_en
	);

	cache_burst_ctr u_burst (
		.clk, .rst_n, .step(burst_step), .clear(burst_clear),
		.src_word (dph_addr[$clog2(`CACHE_BYTES_W) +: $bits(word_sel_t)]),
		.count(burst_count), .last_beat(burst_last), .hit_word(burst_hit_word)
	);

	cache_ctrl u_ctrl (
		.clk, .rst_n, .aphase_read, .aphase_write, .src_haddr, .dph_addr, .dph_byte_en,
		.src_hwdata, .src_hready_resp, .src_hrdata,
		.dst_hready(dst_hready_resp), .dst_hrdata, .dst_haddr, .dst_hwrite, .dst_htrans,
		.dst_hwdata, .burst_step, .burst_clear, .burst_count, .burst_last, .burst_hit_word,
		.tag_addr, .tag_en, .tag_we, .tag_wdata, .tag_rdata,
		.data_addr, .data_en, .data_we, .data_wdata, .data_rdata
	);

	// Tag store, one entry per line
	cache_sram #(.entry_t(tag_entry_t), .DEPTH(`CACHE_DEPTH_WORDS/`CACHE_LINE_WORDS)) u_tag (
		.clk, .addr(tag_addr), .en(tag_en), .we(tag_we), .wdata(tag_wdata), .rdata(tag_rdata)
	);

	// Data store, one RAM per byte lane
	for (genvar i = 0; i < `CACHE_BYTES_W; i++) begin : g_lane
		cache_sram #(.entry_t(byte_t), .DEPTH(`CACHE_DEPTH_WORDS)) u_data (
			.clk,
			.addr  (data_addr),
			.en    (data_en),
			.we    (data_we[i]),
			.wdata (data_wdata[$bits(byte_t)*i +: $bits(byte_t)]),
			.rdata (data_rdata[$bits(byte_t)*i +: $bits(byte_t)])
		);
	end

endmodule

// File: verification/ahb_cache_assertions.sv
// ------------------------------------------------
// AHB-Lite protocol assertions, bound to the cache top
// ------------------------------------------------

`timescale 1ns/10ps

module ahb_cache_assertions (
	input logic               clk,
	input logic               rst_n,
	input logic               src_hready_resp,
	input logic               dst_hready_resp,
	input cache_pkg::addr_t   dst_haddr,
	input logic               dst_hwrite,
	input cache_pkg::htrans_t dst_htrans,
	input cache_pkg::word_t   dst_hwdata
);
	import cache_pkg::*;

	// SEQ only continues a burst
	seq_in_burst: assert property (@(posedge clk) disable iff (!rst_n)
		dst_htrans == HTRANS_SEQ |-> $past(dst_htrans) != HTRANS_IDLE)
		else $error("dst_htrans SEQ without a preceding NONSEQ or SEQ");

	// Wait state freezes the downstream bus
	hold_on_wait: assert property (@(posedge clk) disable iff (!rst_n)
		!dst_hready_resp |=> $stable(dst_haddr) && $stable(dst_htrans) &&
			$stable(dst_hwrite) && $stable(dst_hwdata))
		else $error("downstream outputs changed during a wait state");

	ready_after_reset: assert property (@(posedge clk) $rose(rst_n) |=> src_hready_resp)
		else $error("src_hready_resp low one cycle after reset release");

endmodule

bind ahb_cache_top ahb_cache_assertions u_assertions (
	.clk(clk), .rst_n(rst_n), .src_hready_resp(src_hready_resp),
	.dst_hready_resp(dst_hready_resp), .dst_haddr(dst_haddr), .dst_hwrite(dst_hwrite),
	.dst_htrans(dst_htrans), .dst_hwdata(dst_hwdata)
);

// File: verification/tb_ahb_mem.sv
// ------------------------------------------------
// Downstream AHB-Lite memory with LCG wait states
// ------------------------------------------------

`timescale 1ns/10ps

module tb_ahb_mem #(
	parameter int WORDS = 1024  // 4 KB model
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               wait_en,     // Random wait states when set
	input  logic               hready,
	input  cache_pkg::addr_t   haddr,
	input  logic               hwrite,
	input  cache_pkg::htrans_t htrans,
	input  cache_pkg::word_t   hwdata,
	output logic               hready_resp,
	output cache_pkg::word_t   hrdata
);
	import cache_pkg::*;

	localparam int IDX_W = $clog2(WORDS);

	word_t            mem [WORDS];  // Testbench reads this directly
	logic             dph_active, dph_write;
	logic [IDX_W-1:0] dph_idx;
	logic [1:0]       wait_left;    // Low cycles still to insert
	logic [31:0]      lcg_state;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// Each word holds its byte address XOR a marker
	initial begin
		for (int i = 0; i < WORDS; i++)
			mem[i] = 32'(i * 4) ^ 32'hA5A5_0000;
	end

	assign hrdata = mem[dph_idx];

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dph_active  <= 1'b0;
			dph_write   <= 1'b0;
			dph_idx     <= '0;
			wait_left   <= '0;
			hready_resp <= 1'b1;
			lcg_state   <= 32'd13;  // Seed
		end else if (!hready_resp) begin
			if (wait_left == 2'd0)
				hready_resp <= 1'b1;  // Stretched data phase ends next edge
			else
				wait_left <= wait_left - 2'd1;
		end else begin
			if (dph_active && dph_write)
				mem[dph_idx] <= hwdata;
			dph_active <= hready && htrans != HTRANS_IDLE;
			dph_write  <= hwrite;
			dph_idx    <= haddr[IDX_W+1:2];
			// Draw 0 to 3 wait states for the new data phase
			if (hready && htrans != HTRANS_IDLE && wait_en) begin
				lcg_state <= lcg_next(lcg_state);
				if (lcg_state[17:16] != 2'd0) begin
					hready_resp <= 1'b0;
					wait_left   <= lcg_state[17:16] - 2'd1;
				end
			end
		end
	end

endmodule

// File: verification/tb_ahb_cache.sv
// ------------------------------------------------
// Cache testbench top with clock, file stimulus, checks and watchdog
// ------------------------------------------------

`timescale 1ns/10ps

module tb_ahb_cache;
	import cache_pkg::*;

	localparam int CLK_PERIOD  = 10;
	localparam int MAX_LINES   = 64;
	localparam int COLS        = 5;    // op size addr wdata expected
	localparam int LINE_CYCLES = 400;  // Watchdog budget per data line

	localparam logic [31:0] OP_WRITE = 32'h0, OP_READ = 32'h1, OP_READ_HIT = 32'h2;
	localparam logic [31:0] OP_READ_FILL = 32'h3, OP_READ_CLEAN = 32'h4, OP_MEM = 32'h5;
	localparam logic [31:0] OP_WAITS = 32'h6, OP_END = 32'hF;

	logic       clk, rst_n, wait_en;
	logic       src_hready, src_hwrite, src_hready_resp;
	addr_t      src_haddr, dst_haddr;
	htrans_t    src_htrans, dst_htrans;
	logic [2:0] src_hsize;
	word_t      src_hwdata, src_hrdata, dst_hwdata, dst_hrdata;
	logic       dst_hready_resp, dst_hready, dst_hwrite;

	logic [31:0] stim [MAX_LINES*COLS];
	int          n_lines, errors, checks;
	logic        loaded;
	word_t       rd_data;                             // Data of last read
	int          wait_cycles, n_nonseq, n_seq, n_write;  // Last transfer

	assign src_hready = src_hready_resp;  // Cache is the only upstream slave

	ahb_cache_top uut (
		.clk, .rst_n, .src_hready, .src_haddr, .src_hwrite, .src_htrans, .src_hsize,
		.src_hwdata, .src_hready_resp, .src_hrdata, .dst_hready_resp, .dst_hready,
		.dst_haddr, .dst_hwrite, .dst_htrans, .dst_hwdata, .dst_hrdata
	);

	tb_ahb_mem u_mem (
		.clk, .rst_n, .wait_en, .hready(dst_hready), .haddr(dst_haddr), .hwrite(dst_hwrite),
		.htrans(dst_htrans), .hwdata(dst_hwdata), .hready_resp(dst_hready_resp),
		.hrdata(dst_hrdata)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD/2) clk = ~clk;
	end

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	// Runs one upstream transfer and returns 1 ns after its data phase ends
	task automatic run_transfer(input logic write, input logic [2:0] size, input addr_t addr,
		input word_t wdata);
		addr_t last_addr;
		logic  done;
		wait_cycles = 0;
		n_nonseq    = 0;
		n_seq       = 0;
		n_write     = 0;
		last_addr   = '0;
		done        = 1'b0;
		src_htrans  = HTRANS_NONSEQ;  // Address phase
		src_haddr   = addr;
		src_hwrite  = write;
		src_hsize   = size;
		@(posedge clk);
		#1;
		src_htrans = HTRANS_IDLE;
		src_hwdata = wdata;
		while (!done) begin
			@(negedge clk);
			// Ready to the memory follows the memory's own response
			check_value("dst_hready", 32'(dst_hready), 32'(dst_hready_resp));
			// Downstream beats taken at the coming edge
			if (dst_hready_resp && dst_htrans != HTRANS_IDLE) begin
				if (dst_htrans == HTRANS_NONSEQ) begin
					n_nonseq++;
				end else begin
					n_seq++;
					check_value("dst_haddr", dst_haddr, last_addr + 32'd4);  // Next word
				end
				if (dst_hwrite)
					n_write++;
				last_addr = dst_haddr;
			end
			if (src_hready_resp) begin
				rd_data = src_hrdata;
				done    = 1'b1;
			end else begin
				wait_cycles++;
			end
		end
		@(posedge clk);
		#1;
	endtask

	initial begin : main
		logic [31:0] op, size, addr, wdata, exp_data;
		logic        fill_only;
		rst_n      = 1'b0;
		wait_en    = 1'b0;
		src_htrans = HTRANS_IDLE;
		src_haddr  = '0;
		src_hwrite = 1'b0;
		src_hsize  = 3'd2;
		src_hwdata = '0;
		errors     = 0;
		checks     = 0;
		n_lines    = 0;
		loaded     = 1'b0;
		for (int i = 0; i < MAX_LINES*COLS; i++)
			stim[i] = OP_END;
		$readmemh("verification/cache_testdata.txt", stim);
		while (n_lines < MAX_LINES && stim[n_lines*COLS] != OP_END)
			n_lines++;
		loaded = 1'b1;
		repeat (4) @(posedge clk);
		#1;
		rst_n = 1'b1;
		@(negedge clk);
		check_value("src_hready_resp", 32'(src_hready_resp), 32'd1);
		check_value("dst_htrans", 32'(dst_htrans), 32'(HTRANS_IDLE));
		@(posedge clk);
		#1;
		if (n_lines == 0) begin
			errors++;
			$display("No transfers were read from the data file");
		end
		for (int i = 0; i < n_lines; i++) begin
			op       = stim[i*COLS];
			size     = stim[i*COLS+1];
			addr     = stim[i*COLS+2];
			wdata    = stim[i*COLS+3];
			exp_data = stim[i*COLS+4];
			case (op)
				OP_WRITE: run_transfer(1'b1, size[2:0], addr, wdata);
				OP_READ, OP_READ_HIT, OP_READ_FILL, OP_READ_CLEAN: begin
					run_transfer(1'b0, size[2:0], addr, '0);
					check_value("src_hrdata", rd_data, exp_data);
					if (op == OP_READ_HIT) begin
						check_value("wait_cycles", 32'(wait_cycles), 32'd0);
						check_value("dst_beats", 32'(n_nonseq + n_seq), 32'd0);
					end else if (op != OP_READ) begin
						// Fill only or clean of the victim then fill
						fill_only = op == OP_READ_FILL;
						check_value("dst_nonseq", 32'(n_nonseq), fill_only ? 32'd1 : 32'd2);
						check_value("dst_seq", 32'(n_seq), fill_only ? 32'd3 : 32'd6);
						check_value("dst_writes", 32'(n_write), fill_only ? 32'd0 : 32'd4);
					end
				end
				OP_MEM:   check_value("mem_word", u_mem.mem[addr[11:2]], exp_data);
				OP_WAITS: wait_en = wdata[0];
				default: begin
					errors++;
					$display("Unknown operation %h on data line %0d", op, i);
				end
			endcase
		end
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

	initial begin : watchdog
		wait (loaded);
		repeat (n_lines * LINE_CYCLES + 20) @(posedge clk);
		$display("Timeout: the transfers did not finish within the cycle budget");
		$display("Result: FAILED");
		$finish;
	end

endmodule

// File: verification/cache_testdata.txt
// op size addr wdata expected, hex; op 0 write, 1 read, 2 read hit, 3 read fill,
// 4 read clean+fill, 5 memory word, 6 wait states (wdata bit 0), F end
6 0 00000000 00000000 00000000
3 2 00000048 00000000 A5A50048
2 2 00000048 00000000 A5A50048
0 0 00000049 00003C00 00000000
0 1 0000004A BEEF0000 00000000
2 2 00000048 00000000 BEEF3C48
4 2 00000148 00000000 A5A50148
5 2 00000048 00000000 BEEF3C48
0 2 00000084 12345678 00000000
0 0 0000008B 5A000000 00000000
2 2 00000088 00000000 5AA50088
4 2 00000288 00000000 A5A50288
5 2 00000084 00000000 12345678
5 2 00000088 00000000 5AA50088
6 0 00000000 00000001 00000000
3 2 00000448 00000000 A5A50448
2 2 00000448 00000000 A5A50448
0 0 00000449 00003C00 00000000
0 1 0000044A BEEF0000 00000000
2 2 00000448 00000000 BEEF3C48
4 2 00000548 00000000 A5A50548
5 2 00000448 00000000 BEEF3C48
0 2 00000484 12345678 00000000
0 0 0000048B 5A000000 00000000
2 2 00000488 00000000 5AA50488
4 2 00000688 00000000 A5A50688
5 2 00000484 00000000 12345678
5 2 00000488 00000000 5AA50488
F 0 00000000 00000000 00000000

// File: verilog.f
+incdir+rtl
rtl/cache_pkg.sv
rtl/cache_sram.sv
rtl/cache_src_capture.sv
rtl/cache_burst_ctr.sv
rtl/cache_ctrl.sv
rtl/ahb_cache_top.sv
verification/ahb_cache_assertions.sv
verification/tb_ahb_mem.sv
verification/tb_ahb_cache.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the cache testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert -Wno-fatal --top-module tb_ahb_cache -f verilog.f; then
	echo "Verilator build failed"
	exit 1
fi

if ! sim_out=$(./obj_dir/Vtb_ahb_cache 2>&1); then
	echo "$sim_out"
	echo "Simulation exited with an error status"
	exit 1
fi
echo "$sim_out"

if grep -qx "Result: PASSED" <<< "$sim_out"; then
	exit 0
fi
exit 1
